// File: common/led_drive_params.svh
`ifndef LED_DRIVE_PARAMS_SVH
`define LED_DRIVE_PARAMS_SVH

////////////////////////////////////////
// Driver chain geometry
////////////////////////////////////////

// Parallel serial lanes into the driver chain
`define DRIVER_LANES 2

// Data bits per lane in one frame, select bit not counted
`define LANE_BITS 24

////////////////////////////////////////
// Grayscale clock
////////////////////////////////////////

// clock_33 cycles with gclk held low after each latch
`define BLANKING_TIME 72

`endif

// File: common/led_drive_pkg.sv
`include "led_drive_params.svh"

package led_drive_pkg;

    ////////////////////////////////////////
    // Payload types
    ////////////////////////////////////////

    // One lane worth of frame data
    typedef logic [`LANE_BITS-1:0] lane_word_t;

    // One display column, lane 0 in the low bits
    typedef struct packed {
        lane_word_t [`DRIVER_LANES-1:0] lane;
    } column_t;

    // Driver configuration, same layout as a column
    typedef struct packed {
        lane_word_t [`DRIVER_LANES-1:0] lane;
    } config_t;

    ////////////////////////////////////////
    // Control types
    ////////////////////////////////////////

    // Encoding is the select bit sent ahead of the data
    typedef enum logic {
        FRAME_GRAY   = 1'b0,
        FRAME_CONFIG = 1'b1
    } frame_kind_e;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_SHIFT,
        SEQ_WAIT_SYNC,
        SEQ_LATCH,
        SEQ_BLANK
    } seq_state_e;

    // Frame handed from sequencer to shifter
    typedef struct packed {
        frame_kind_e                    kind;
        lane_word_t [`DRIVER_LANES-1:0] lane;
    } shift_req_t;

endpackage

// File: source/driver_config_regs.sv
module driver_config_regs (
    input  logic                   clock_33,
    input  logic                   nrst,
    // Configuration port from software
    input  logic                   cfg_valid,
    output logic                   cfg_ready,
    input  led_drive_pkg::config_t cfg_data,
    // Towards the sequencer
    input  logic                   cfg_taken,
    output logic                   cfg_pending,
    output led_drive_pkg::config_t cfg_word
);

    logic cfg_accept;

    // Holding register is free once the sequencer took the last word
    assign cfg_ready  = ~cfg_pending;
    assign cfg_accept = cfg_valid & cfg_ready;

    ////////////////////////////////////////
    // Pending flag
    ////////////////////////////////////////

    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            cfg_pending <= 1'b0;
        end else if (cfg_accept) begin
            cfg_pending <= 1'b1;
        end else if (cfg_taken) begin
            // Word went out in a config frame
            cfg_pending <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // Configuration word
    ////////////////////////////////////////

    // Only written on a handshake, so stable while pending
    always_ff @(posedge clock_33) begin
        if (cfg_accept) begin
            cfg_word <= cfg_data;
        end
    end

endmodule

// File: driver/driver_shifter.sv
`include "led_drive_params.svh"

module driver_shifter (
    input  logic                      clock_33,
    input  logic                      nrst,
    // Frame request from the sequencer
    input  logic                      shift_start,
    input  led_drive_pkg::shift_req_t shift_req,
    output logic                      shift_done,
    // Serial lines to the driver chain
    output logic [`DRIVER_LANES-1:0]  driver_sin,
    output logic                      driver_sclk
);

    // Select bit plus data bits
    localparam int FRAME_BITS = 1 + `LANE_BITS;
    localparam int CNT_W      = $clog2(FRAME_BITS);

    logic [`DRIVER_LANES-1:0][FRAME_BITS-1:0] lane_sr;
    logic                                     busy;
    logic                                     sclk_q;
    logic [CNT_W-1:0]                         bit_cnt;
    logic                                     last_bit;

    assign last_bit = (bit_cnt == CNT_W'(FRAME_BITS - 1));

    ////////////////////////////////////////
    // Bit sequencing
    ////////////////////////////////////////

    // Each bit spends one cycle with sclk low and one with sclk high.
    // The register moves on only as sclk falls, so the drivers see
    // stable data around every rising edge.
    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            busy    <= 1'b0;
            sclk_q  <= 1'b0;
            bit_cnt <= '0;
        end else if (!busy) begin
            if (shift_start) begin
                busy    <= 1'b1;
                sclk_q  <= 1'b0;
                bit_cnt <= '0;
            end
        end else if (!sclk_q) begin
            // Rising edge of the shift clock
            sclk_q <= 1'b1;
        end else begin
            sclk_q <= 1'b0;
            if (last_bit) begin
                busy <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Lane shift registers
    ////////////////////////////////////////

    // Zeros are shifted in behind the frame, which leaves the lines
    // low once the last bit has gone out
    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            lane_sr <= '0;
        end else if (!busy) begin
            if (shift_start) begin
                for (int i = 0; i < `DRIVER_LANES; i++) begin
                    lane_sr[i] <= {shift_req.kind, shift_req.lane[i]};
                end
            end
        end else if (sclk_q) begin
            for (int i = 0; i < `DRIVER_LANES; i++) begin
                lane_sr[i] <= {lane_sr[i][FRAME_BITS-2:0], 1'b0};
            end
        end
    end

    ////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////

    // MSB of each register is the bit on the line
    always_comb begin
        for (int i = 0; i < `DRIVER_LANES; i++) begin
            driver_sin[i] = lane_sr[i][FRAME_BITS-1];
        end
    end

    assign driver_sclk = sclk_q;

    // High during the sclk-high half of the final bit
    assign shift_done = busy & sclk_q & last_bit;

endmodule

// File: driver/gclk_blanker.sv
`include "led_drive_params.svh"

module gclk_blanker (
    input  logic clock_33,
    input  logic nrst,
    input  logic lat_pulse,
    output logic blanking,
    output logic driver_gclk
);

    localparam int CNT_W = $clog2(`BLANKING_TIME + 1);

    logic [CNT_W-1:0] blank_cnt;
    logic [CNT_W-1:0] blank_cnt_nxt;
    logic             gclk_q;

    ////////////////////////////////////////
    // Blanking counter
    ////////////////////////////////////////

    // Latch restarts the count
    always_comb begin
        if (lat_pulse) begin
            blank_cnt_nxt = CNT_W'(`BLANKING_TIME);
        end else if (blank_cnt != '0) begin
            blank_cnt_nxt = blank_cnt - 1'b1;
        end else begin
            blank_cnt_nxt = '0;
        end
    end

    // High while gclk is still to be held low in the next cycle
    assign blanking = (blank_cnt_nxt != '0);

    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            blank_cnt <= '0;
            gclk_q    <= 1'b0;
        end else begin
            blank_cnt <= blank_cnt_nxt;
            // Free running half-rate clock outside blanking
            gclk_q    <= blanking ? 1'b0 : ~gclk_q;
        end
    end

    assign driver_gclk = gclk_q;

endmodule

// File: driver/driver_sequencer.sv
module driver_sequencer (
    input  logic                       clock_33,
    input  logic                       nrst,
    // Column port
    input  logic                       col_valid,
    output logic                       col_ready,
    input  led_drive_pkg::column_t     col_data,
    // Configuration holding register
    input  logic                       cfg_pending,
    input  led_drive_pkg::config_t     cfg_word,
    output logic                       cfg_taken,
    input  logic                       position_sync,
    // Shifter
    output logic                       shift_start,
    output led_drive_pkg::shift_req_t  shift_req,
    input  logic                       shift_done,
    // Latch and grayscale clock
    output logic                       lat_pulse,
    input  logic                       blanking
);

    led_drive_pkg::seq_state_e  state;
    led_drive_pkg::seq_state_e  state_nxt;
    led_drive_pkg::frame_kind_e kind_q;

    ////////////////////////////////////////
    // Next state and handshakes
    ////////////////////////////////////////

    always_comb begin
        state_nxt      = state;
        col_ready      = 1'b0;
        cfg_taken      = 1'b0;
        shift_start    = 1'b0;
        shift_req.kind = led_drive_pkg::FRAME_GRAY;
        shift_req.lane = col_data.lane;

        case (state)
            led_drive_pkg::SEQ_IDLE: begin
                // Configuration goes ahead of any waiting column
                col_ready = ~cfg_pending;
                if (cfg_pending) begin
                    cfg_taken      = 1'b1;
                    shift_start    = 1'b1;
                    shift_req.kind = led_drive_pkg::FRAME_CONFIG;
                    shift_req.lane = cfg_word.lane;
                    state_nxt      = led_drive_pkg::SEQ_SHIFT;
                end else if (col_valid) begin
                    shift_start = 1'b1;
                    state_nxt   = led_drive_pkg::SEQ_SHIFT;
                end
            end
            led_drive_pkg::SEQ_SHIFT: begin
                if (shift_done) begin
                    // Only grayscale data is tied to rotor position
                    if (kind_q == led_drive_pkg::FRAME_CONFIG) begin
                        state_nxt = led_drive_pkg::SEQ_LATCH;
                    end else begin
                        state_nxt = led_drive_pkg::SEQ_WAIT_SYNC;
                    end
                end
            end
            led_drive_pkg::SEQ_WAIT_SYNC: begin
                if (position_sync) begin
                    state_nxt = led_drive_pkg::SEQ_LATCH;
                end
            end
            led_drive_pkg::SEQ_LATCH: begin
                state_nxt = led_drive_pkg::SEQ_BLANK;
            end
            led_drive_pkg::SEQ_BLANK: begin
                if (!blanking) begin
                    state_nxt = led_drive_pkg::SEQ_IDLE;
                end
            end
            default: begin
                state_nxt = led_drive_pkg::SEQ_IDLE;
            end
        endcase
    end

    ////////////////////////////////////////
    // State and frame kind
    ////////////////////////////////////////

    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            state  <= led_drive_pkg::SEQ_IDLE;
            kind_q <= led_drive_pkg::FRAME_GRAY;
        end else begin
            state <= state_nxt;
            if (shift_start) begin
                kind_q <= shift_req.kind;
            end
        end
    end

    // One cycle latch straight from the state register
    assign lat_pulse = (state == led_drive_pkg::SEQ_LATCH);

endmodule

// File: source/led_column_top.sv
`include "led_drive_params.svh"

module led_column_top (
    input  logic                     clock_33,
    input  logic                     nrst,
    // Column input
    input  logic                     col_valid,
    output logic                     col_ready,
    input  led_drive_pkg::column_t   col_data,
    // Configuration input
    input  logic                     cfg_valid,
    output logic                     cfg_ready,
    input  led_drive_pkg::config_t   cfg_data,
    input  logic                     position_sync,
    // Driver chain
    output logic [`DRIVER_LANES-1:0] driver_sin,
    output logic                     driver_sclk,
    output logic                     driver_lat,
    output logic                     driver_gclk
);

    logic                      cfg_pending;
    led_drive_pkg::config_t    cfg_word;
    logic                      cfg_taken;
    logic                      shift_start;
    led_drive_pkg::shift_req_t shift_req;
    logic                      shift_done;
    logic                      blanking;

    ////////////////////////////////////////
    // Configuration and control
    ////////////////////////////////////////

    driver_config_regs u_config_regs (
        .clock_33    (clock_33),
        .nrst        (nrst),
        .cfg_valid   (cfg_valid),
        .cfg_ready   (cfg_ready),
        .cfg_data    (cfg_data),
        .cfg_taken   (cfg_taken),
        .cfg_pending (cfg_pending),
        .cfg_word    (cfg_word)
    );

    // Latch pulse goes to the pin and to the blanker
    driver_sequencer u_sequencer (
        .clock_33      (clock_33),
        .nrst          (nrst),
        .col_valid     (col_valid),
        .col_ready     (col_ready),
        .col_data      (col_data),
        .cfg_pending   (cfg_pending),
        .cfg_word      (cfg_word),
        .cfg_taken     (cfg_taken),
        .position_sync (position_sync),
        .shift_start   (shift_start),
        .shift_req     (shift_req),
        .shift_done    (shift_done),
        .lat_pulse     (driver_lat),
        .blanking      (blanking)
    );

    ////////////////////////////////////////
    // Serial lines and grayscale clock
    ////////////////////////////////////////

    driver_shifter u_shifter (
        .clock_33    (clock_33),
        .nrst        (nrst),
        .shift_start (shift_start),
        .shift_req   (shift_req),
        .shift_done  (shift_done),
        .driver_sin  (driver_sin),
        .driver_sclk (driver_sclk)
    );

    gclk_blanker u_gclk_blanker (
        .clock_33    (clock_33),
        .nrst        (nrst),
        .lat_pulse   (driver_lat),
        .blanking    (blanking),
        .driver_gclk (driver_gclk)
    );

endmodule

// File: tests/led_column_chk.sv
`include "led_drive_params.svh"

module led_column_chk (
    input logic                     clock_33,
    input logic                     nrst,
    input logic                     col_valid,
    input logic                     col_ready,
    input led_drive_pkg::column_t   col_data,
    input logic [`DRIVER_LANES-1:0] driver_sin,
    input logic                     driver_sclk,
    input logic                     driver_lat
);
    timeunit 1ns;
    timeprecision 1ps;

    // Latch is a single cycle pulse
    lat_single_cycle: assert property (@(posedge clock_33) disable iff (!nrst)
        driver_lat |=> !driver_lat)
        else $error("driver_lat high for more than one cycle");

    // Drivers sample on the rising shift clock
    sin_stable_at_sclk_rise: assert property (@(posedge clock_33) disable iff (!nrst)
        $rose(driver_sclk) |-> $stable(driver_sin))
        else $error("driver_sin changed as driver_sclk rose");

    col_held_until_ready: assert property (@(posedge clock_33) disable iff (!nrst)
        col_valid && !col_ready |=> col_valid && $stable(col_data))
        else $error("column dropped or changed before col_ready");

endmodule

bind led_column_top led_column_chk u_chk (
    .clock_33    (clock_33),
    .nrst        (nrst),
    .col_valid   (col_valid),
    .col_ready   (col_ready),
    .col_data    (col_data),
    .driver_sin  (driver_sin),
    .driver_sclk (driver_sclk),
    .driver_lat  (driver_lat)
);

// File: tests/led_column_tb.sv
`include "led_drive_params.svh"

module led_column_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_BITS = 1 + `LANE_BITS;
    localparam int WAIT_LIMIT = 4 * (2 * FRAME_BITS + `BLANKING_TIME + 8);
    localparam int NUM_TESTS  = 5;
    localparam int WATCHDOG   = NUM_TESTS * (2 * FRAME_BITS + `BLANKING_TIME + 200) * 10;

    typedef logic [`DRIVER_LANES-1:0][FRAME_BITS-1:0] frame_t;

    logic                     clock_33;
    logic                     nrst;
    logic                     col_valid;
    logic                     col_ready;
    led_drive_pkg::column_t   col_data;
    logic                     cfg_valid;
    logic                     cfg_ready;
    led_drive_pkg::config_t   cfg_data;
    logic                     position_sync;
    logic [`DRIVER_LANES-1:0] driver_sin;
    logic                     driver_sclk;
    logic                     driver_lat;
    logic                     driver_gclk;

    int          error_count;
    int          check_count;
    int          lat_count;
    int          rx_bits;
    frame_t      rx_acc;
    frame_t      rx_frames[$];
    logic [31:0] lfsr_state;

    led_column_top u_dut (.*);

    initial begin
        clock_33 = 1'b0;
        forever #5 clock_33 = ~clock_33;
    end

    initial begin
        #WATCHDOG;
        $display("Error: watchdog expired before the tests finished");
        $display("Test failed");
        $finish;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic check(input bit ok, input string msg);
        check_count++;
        assert (ok) else begin
            error_count++;
            $display("Mismatch at %0t: %s", $time, msg);
        end
    endtask

    task automatic timeout_error(input string what);
        error_count++;
        $display("Error at %0t: timed out waiting for %s", $time, what);
    endtask

    // Galois LFSR, one step per random bit
    function automatic logic next_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = (lfsr_state >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
        return b;
    endfunction

    function automatic led_drive_pkg::column_t random_column();
        led_drive_pkg::column_t c;
        for (int i = 0; i < `DRIVER_LANES; i++) begin
            for (int b = 0; b < `LANE_BITS; b++) begin
                c.lane[i][b] = next_bit();
            end
        end
        return c;
    endfunction

    // Select bit first, then the lane data MSB first
    function automatic frame_t expected_frame(input logic sel, input led_drive_pkg::column_t c);
        frame_t f;
        for (int i = 0; i < `DRIVER_LANES; i++) begin
            f[i] = {sel, c.lane[i]};
        end
        return f;
    endfunction

    task automatic compare_frame(input frame_t want, input string what);
        frame_t got;
        if (rx_frames.size() == 0) begin
            error_count++;
            $display("Error at %0t: no frame was latched for %s", $time, what);
            return;
        end
        got = rx_frames.pop_front();
        check(got == want, $sformatf("%s frame %h, expected %h", what, got, want));
    endtask

    // Offer a configuration word and/or a column, each held until accepted
    task automatic transfer(input logic send_cfg, input led_drive_pkg::config_t cfg,
                            input logic send_col, input led_drive_pkg::column_t col);
        logic cfg_done;
        logic col_done;
        int   cycles;
        cfg_done = ~send_cfg;
        col_done = ~send_col;
        cycles   = 0;
        @(posedge clock_33);
        #1;
        cfg_valid = send_cfg;
        col_valid = send_col;
        cfg_data  = cfg;
        col_data  = col;
        while (!(cfg_done && col_done) && cycles < WAIT_LIMIT) begin
            @(posedge clock_33);
            cfg_done = cfg_done | (cfg_valid & cfg_ready);
            col_done = col_done | (col_valid & col_ready);
            cycles++;
            #1;
            cfg_valid = cfg_valid & ~cfg_done;
            col_valid = col_valid & ~col_done;
        end
        if (!(cfg_done && col_done)) begin
            timeout_error("the input handshake");
        end
    endtask

    task automatic wait_latches(input int target, input string what);
        int cycles;
        cycles = 0;
        while (lat_count < target && cycles < WAIT_LIMIT) begin
            @(posedge clock_33);
            cycles++;
        end
        if (lat_count < target) begin
            timeout_error(what);
        end
    endtask

    ////////////////////////////////////////
    // Serial line monitor
    ////////////////////////////////////////

    // One sclk high cycle per bit, the latch closes the frame
    always @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            rx_bits   <= 0;
            lat_count <= 0;
        end else begin
            if (driver_sclk) begin
                for (int i = 0; i < `DRIVER_LANES; i++) begin
                    rx_acc[i] <= {rx_acc[i][FRAME_BITS-2:0], driver_sin[i]};
                end
                rx_bits <= rx_bits + 1;
            end
            if (driver_lat) begin
                check(rx_bits == FRAME_BITS, $sformatf("latched frame has %0d bits", rx_bits));
                rx_frames.push_back(rx_acc);
                rx_bits   <= 0;
                lat_count <= lat_count + 1;
            end
        end
    end

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic reset_values();
        repeat (10) @(posedge clock_33);
        check(driver_lat == 1'b0 && driver_sclk == 1'b0, "latch or shift clock high in reset");
        check(driver_sin == '0 && driver_gclk == 1'b0, "serial data or gclk high in reset");
        check(col_ready && cfg_ready, "input ready low in reset");
        #1 nrst = 1'b1;
    endtask

    task automatic gray_frame_and_blanking();
        led_drive_pkg::column_t col;
        int                     start;
        int                     cycles;
        start  = lat_count;
        col    = random_column();
        cycles = 0;
        transfer(1'b0, '0, 1'b1, col);
        while (!driver_lat && cycles < WAIT_LIMIT) begin
            @(posedge clock_33);
            cycles++;
        end
        if (!driver_lat) begin
            timeout_error("the grayscale latch");
        end
        repeat (`BLANKING_TIME) begin
            @(posedge clock_33);
            check(driver_gclk == 1'b0, "gclk not held low during blanking");
        end
        for (int k = 0; k < 8; k++) begin
            @(posedge clock_33);
            check(driver_gclk == ~k[0], "gclk not toggling after blanking");
        end
        check(lat_count == start + 1, "latch count after one grayscale frame");
        compare_frame(expected_frame(1'b0, col), "grayscale");
    endtask

    task automatic config_priority();
        led_drive_pkg::column_t first_col;
        led_drive_pkg::column_t next_col;
        led_drive_pkg::column_t cfg_lanes;
        led_drive_pkg::config_t cfg;
        int                     start;
        start     = lat_count;
        first_col = random_column();
        cfg_lanes = random_column();
        next_col  = random_column();
        cfg.lane  = cfg_lanes.lane;
        // Both offered while the first column is still in flight
        transfer(1'b0, '0, 1'b1, first_col);
        transfer(1'b1, cfg, 1'b1, next_col);
        wait_latches(start + 3, "the configuration priority frames");
        compare_frame(expected_frame(1'b0, first_col), "leading grayscale");
        compare_frame(expected_frame(1'b1, cfg_lanes), "configuration");
        compare_frame(expected_frame(1'b0, next_col), "held grayscale");
    endtask

    task automatic sync_gating();
        led_drive_pkg::column_t col;
        int                     start;
        int                     cycles;
        start  = lat_count;
        col    = random_column();
        cycles = 0;
        @(posedge clock_33);
        #1 position_sync = 1'b0;
        transfer(1'b0, '0, 1'b1, col);
        while (rx_bits < FRAME_BITS && cycles < WAIT_LIMIT) begin
            @(posedge clock_33);
            cycles++;
        end
        if (rx_bits < FRAME_BITS) begin
            timeout_error("the grayscale bits");
        end
        repeat (20) begin
            @(posedge clock_33);
            check(driver_lat == 1'b0, "latch issued while position_sync is low");
        end
        // Also catches a latch right behind the last shifted bit
        check(lat_count == start, "grayscale frame latched before position_sync rose");
        #1 position_sync = 1'b1;
        wait_latches(start + 1, "the latch after position_sync");
        compare_frame(expected_frame(1'b0, col), "synchronized grayscale");
    endtask

    task automatic column_stream();
        led_drive_pkg::column_t cols[5];
        int                     start;
        start = lat_count;
        for (int k = 0; k < 5; k++) begin
            cols[k] = random_column();
            transfer(1'b0, '0, 1'b1, cols[k]);
        end
        wait_latches(start + 5, "the column stream");
        for (int k = 0; k < 5; k++) begin
            compare_frame(expected_frame(1'b0, cols[k]), $sformatf("stream column %0d", k));
        end
    endtask

    initial begin
        nrst          = 1'b0;
        col_valid     = 1'b0;
        col_data      = '0;
        cfg_valid     = 1'b0;
        cfg_data      = '0;
        position_sync = 1'b1;
        error_count   = 0;
        check_count   = 0;
        lfsr_state    = 32'd91320;
        reset_values();
        gray_frame_and_blanking();
        config_priority();
        sync_gating();
        column_stream();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+common
common/led_drive_pkg.sv
source/driver_config_regs.sv
driver/driver_shifter.sv
driver/gclk_blanker.sv
driver/driver_sequencer.sv
source/led_column_top.sv
tests/led_column_chk.sv
tests/led_column_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the LED column testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f filelist.f --top-module led_column_tb -o led_column_sim
./obj_dir/led_column_sim > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
